// File: tb.f
+incdir+logic
logic/ooo_pkg.sv
logic/psel_gen.sv
logic/rs.sv
logic/issue_select.sv
logic/exec_unit.sv
logic/ooo_core.sv
testbench/ooo_checker.sv
testbench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, fail on build error or failed run
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// File: testbench/tb_top.sv
`timescale 1ns/1ns
`include "ooo_defines.svh"

module tb_top import ooo_pkg::*; ();

    localparam int NTAGS       = 1 << `TAG_W;
    localparam int RUN_CYCLES  = 400;
    localparam int DRAIN       = 20;
    localparam int WATCHDOG_NS = (3 + RUN_CYCLES + DRAIN + 100) * 20;

    logic                                   clock;
    logic                                   reset;
    logic [`CNT_W-1:0]                      dispatch_count;
    logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_dest, dispatch_src1, dispatch_src2;
    logic [`NUM_DISPATCH-1:0]               dispatch_src1_ready, dispatch_src2_ready;
    op_t  [`NUM_DISPATCH-1:0]               dispatch_op;
    logic [`NUM_DISPATCH-1:0][`BMASK_W-1:0] dispatch_bmask;
    logic [`CNT_W-1:0]                      rs_spots;
    logic [`BMASK_W-1:0]                    resolve_mask;
    logic                                   mispredict;
    logic                                   issue_valid;
    logic [`TAG_W-1:0]                      issue_tag;
    op_t                                    issue_op;
    logic [`BMASK_W-1:0]                    issue_bmask;
    logic [`NUM_DISPATCH-1:0]               cdb_valid;
    logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   cdb_tag;

    // tag life as the testbench sees it, 0 free, 1 in flight, 2 completed
    logic [1:0]          tag_state [NTAGS];
    logic [`BMASK_W-1:0] tag_mask [NTAGS];
    logic [`BMASK_W-1:0] active_br;
    logic [31:0]         rng;
    int                  next_tag;
    int                  errors;

    ooo_core dut_i (
        .clock(clock), .reset(reset),
        .dispatch_count(dispatch_count),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src2_ready(dispatch_src2_ready),
        .dispatch_op(dispatch_op),
        .dispatch_bmask(dispatch_bmask),
        .rs_spots(rs_spots),
        .resolve_mask(resolve_mask),
        .mispredict(mispredict),
        .issue_valid(issue_valid),
        .issue_tag(issue_tag),
        .issue_op(issue_op),
        .issue_bmask(issue_bmask),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // recent tag as a source, a producer still in flight passes its branches on
    task automatic pick_source(input logic [`TAG_W-1:0] dest, input logic [1:0] back,
                               output logic [`TAG_W-1:0] src, output logic rdy,
                               inout logic [`BMASK_W-1:0] m);
        src = dest - `TAG_W'(back) - `TAG_W'(1);
        rdy = (tag_state[src] != 2'd1);
        if (!rdy) begin
            m = m | tag_mask[src];
        end
    endtask

    task automatic drive_cycle(input logic allow_dispatch);
        int                  cnt;
        int                  bit_i;
        logic [`TAG_W-1:0]   d;
        logic [`BMASK_W-1:0] m;
        dispatch_count = '0;
        resolve_mask   = '0;
        mispredict     = 1'b0;
        rng = xorshift(rng);
        // resolve a live branch now and then, a third of them wrong
        bit_i = int'(rng[9:8]);
        if (rng[3:0] < 4'd3 && active_br[bit_i]) begin
            resolve_mask = `BMASK_W'(1) << bit_i;
            mispredict   = (rng[20:16] % 5'd3) == 5'd0;
        end
        // open a new branch on a free bit
        bit_i = int'(rng[25:24]);
        if (rng[23:22] == 2'd0 && !resolve_mask[bit_i]) begin
            active_br[bit_i] = 1'b1;
        end
        cnt = allow_dispatch ? int'(rng[27:26]) % (int'(rs_spots) + 1) : 0;
        for (int k = 0; k < cnt; k++) begin
            // round robin over tags that are not in flight
            for (int j = 0; j < NTAGS; j++) begin
                if (tag_state[(next_tag + j) % NTAGS] != 2'd1) begin
                    next_tag = (next_tag + j) % NTAGS;
                    break;
                end
            end
            d = `TAG_W'(next_tag);
            next_tag = (next_tag + 1) % NTAGS;
            rng = xorshift(rng);
            m = '0;
            bit_i = int'(rng[4:3]);
            if (rng[2] && active_br[bit_i]) begin
                m = `BMASK_W'(1) << bit_i;
            end
            pick_source(d, rng[6:5], dispatch_src1[k], dispatch_src1_ready[k], m);
            pick_source(d, rng[8:7], dispatch_src2[k], dispatch_src2_ready[k], m);
            dispatch_dest[k]  = d;
            dispatch_op[k]    = op_t'(rng[1:0]);
            dispatch_bmask[k] = m;
            tag_state[d]      = 2'd1;
            tag_mask[d]       = m;
        end
        dispatch_count = `CNT_W'(cnt);
    endtask

    // completions and squashes seen late in the cycle free their tags
    task automatic observe_cycle();
        for (int k = 0; k < `NUM_DISPATCH; k++) begin
            if (cdb_valid[k]) begin
                tag_state[cdb_tag[k]] = 2'd2;
            end
        end
        for (int t = 0; t < NTAGS; t++) begin
            if (mispredict && tag_state[t] == 2'd1 && |(tag_mask[t] & resolve_mask)) begin
                tag_state[t] = 2'd0;
            end
            tag_mask[t] = tag_mask[t] & ~resolve_mask;
        end
        active_br = active_br & ~resolve_mask;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset               = 1'b1;
        dispatch_count      = '0;
        dispatch_dest       = '0;
        dispatch_src1       = '0;
        dispatch_src2       = '0;
        dispatch_src1_ready = '0;
        dispatch_src2_ready = '0;
        dispatch_op         = {`NUM_DISPATCH{OP_ADD}};
        dispatch_bmask      = '0;
        resolve_mask        = '0;
        mispredict          = 1'b0;
        rng                 = 32'ha13708e3;
        active_br           = '0;
        next_tag            = 0;
        for (int t = 0; t < NTAGS; t++) begin
            tag_state[t] = 2'd0;
            tag_mask[t]  = '0;
        end
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int c = 0; c < RUN_CYCLES + DRAIN; c++) begin
            drive_cycle(c < RUN_CYCLES);
            @(negedge clock);
            observe_cycle();
            @(posedge clock);
            #2;
        end
        errors = dut_i.checker_i.fail_count;
        $display("assertion failures: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: testbench/ooo_checker.sv
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_checker import ooo_pkg::*; (
    input logic                                   clock,
    input logic                                   reset,
    input logic [`CNT_W-1:0]                      dispatch_count,
    input logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_dest,
    input logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_src1,
    input logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_src2,
    input logic [`NUM_DISPATCH-1:0]               dispatch_src1_ready,
    input logic [`NUM_DISPATCH-1:0]               dispatch_src2_ready,
    input op_t  [`NUM_DISPATCH-1:0]               dispatch_op,
    input logic [`NUM_DISPATCH-1:0][`BMASK_W-1:0] dispatch_bmask,
    input logic [`CNT_W-1:0]                      rs_spots,
    input logic [`BMASK_W-1:0]                    resolve_mask,
    input logic                                   mispredict,
    input logic                                   issue_valid,
    input logic [`TAG_W-1:0]                      issue_tag,
    input op_t                                    issue_op,
    input logic [`BMASK_W-1:0]                    issue_bmask,
    input logic [`NUM_DISPATCH-1:0]               cdb_valid,
    input logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   cdb_tag
);

    localparam int NTAGS = 1 << `TAG_W;

    int fail_count = 0;

    // scoreboard bits per tag, cleared when the tag is dispatched again
    logic [NTAGS-1:0]    disp, issued, squashed, done, s1ok, s2ok;
    logic [`TAG_W-1:0]   s1 [NTAGS];
    logic [`TAG_W-1:0]   s2 [NTAGS];
    // opcode given at dispatch
    op_t                 op_rec [NTAGS];
    // dispatched mask less the bits resolved since
    logic [`BMASK_W-1:0] cur_mask [NTAGS];
    logic [1:0]          since_dispatch;

    // expected completions, one ALU stage and MUL_LAT multiplier stages
    logic                              alu_v;
    logic [`TAG_W-1:0]                 alu_t;
    logic [`BMASK_W-1:0]               alu_m;
    logic [`MUL_LAT-1:0]               mul_v;
    logic [`MUL_LAT-1:0][`TAG_W-1:0]   mul_t;
    logic [`MUL_LAT-1:0][`BMASK_W-1:0] mul_m;
    logic                              issue_live, alu_exp, mul_exp;

    function automatic logic killed(input logic [`BMASK_W-1:0] m);
        return mispredict && |(m & resolve_mask);
    endfunction

    function automatic logic bus_hit(input logic [`TAG_W-1:0] t);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `NUM_DISPATCH; k++) begin
            if (cdb_valid[k] && cdb_tag[k] == t) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign issue_live = issue_valid && !killed(issue_bmask);
    assign alu_exp    = alu_v && !killed(alu_m);
    assign mul_exp    = mul_v[`MUL_LAT-1] && !killed(mul_m[`MUL_LAT-1]);

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_v <= 1'b0;
            mul_v <= '0;
        end else begin
            alu_v    <= issue_live && issue_op != OP_MUL;
            mul_v[0] <= issue_live && issue_op == OP_MUL;
            for (int s = 1; s < `MUL_LAT; s++) begin
                mul_v[s] <= mul_v[s-1] && !killed(mul_m[s-1]);
            end
        end
        alu_t    <= issue_tag;
        alu_m    <= issue_bmask & ~resolve_mask;
        mul_t[0] <= issue_tag;
        mul_m[0] <= issue_bmask & ~resolve_mask;
        for (int s = 1; s < `MUL_LAT; s++) begin
            mul_t[s] <= mul_t[s-1];
            mul_m[s] <= mul_m[s-1] & ~resolve_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            disp           <= '0;
            issued         <= '0;
            squashed       <= '0;
            done           <= '0;
            s1ok           <= '0;
            s2ok           <= '0;
            since_dispatch <= '0;
        end else begin
            // counts up to 2 from the first dispatch
            if ((since_dispatch != 0 || dispatch_count != 0) && since_dispatch != 2'd2) begin
                since_dispatch <= since_dispatch + 2'd1;
            end
            for (int t = 0; t < NTAGS; t++) begin
                cur_mask[t] <= cur_mask[t] & ~resolve_mask;
                if (disp[t] && !done[t] && killed(cur_mask[t])) begin
                    squashed[t] <= 1'b1;
                end
                if (bus_hit(s1[t])) begin
                    s1ok[t] <= 1'b1;
                end
                if (bus_hit(s2[t])) begin
                    s2ok[t] <= 1'b1;
                end
                if (bus_hit(`TAG_W'(t))) begin
                    done[t] <= 1'b1;
                end
            end
            if (issue_valid) begin
                issued[issue_tag] <= 1'b1;
            end
            // a new instance of a tag starts with a clean record
            for (int k = 0; k < `NUM_DISPATCH; k++) begin
                if (k < int'(dispatch_count)) begin
                    disp[dispatch_dest[k]]     <= 1'b1;
                    issued[dispatch_dest[k]]   <= 1'b0;
                    done[dispatch_dest[k]]     <= 1'b0;
                    squashed[dispatch_dest[k]] <= killed(dispatch_bmask[k]);
                    s1[dispatch_dest[k]]       <= dispatch_src1[k];
                    s2[dispatch_dest[k]]       <= dispatch_src2[k];
                    s1ok[dispatch_dest[k]]     <= dispatch_src1_ready[k]
                                                | bus_hit(dispatch_src1[k]);
                    s2ok[dispatch_dest[k]]     <= dispatch_src2_ready[k]
                                                | bus_hit(dispatch_src2[k]);
                    op_rec[dispatch_dest[k]]   <= dispatch_op[k];
                    cur_mask[dispatch_dest[k]] <= dispatch_bmask[k] & ~resolve_mask;
                end
            end
        end
    end

    // nothing can leave the core before a dispatch has had time to issue
    quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
        since_dispatch < 2'd2 |-> !issue_valid && cdb_valid == '0)
    else begin
        $error("[ERROR] issue_valid %h cdb_valid %h before any issue", issue_valid, cdb_valid);
        fail_count++;
    end

    spots_bound: assert property (@(posedge clock) disable iff (reset)
        rs_spots <= `CNT_W'(`NUM_DISPATCH))
    else begin
        $error("[ERROR] rs_spots %h above %h", rs_spots, `NUM_DISPATCH);
        fail_count++;
    end

    issue_legal: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> disp[issue_tag] && !issued[issue_tag] && !squashed[issue_tag])
    else begin
        $error("[ERROR] issue_tag %h dispatched %h issued %h squashed %h", issue_tag,
               disp[issue_tag], issued[issue_tag], squashed[issue_tag]);
        fail_count++;
    end

    // the issued op and mask belong to the instruction dispatched under that tag
    issue_payload: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> issue_op == op_rec[issue_tag] && issue_bmask == cur_mask[issue_tag])
    else begin
        $error("[ERROR] issue_tag %h issue_op %h expected %h issue_bmask %h expected %h",
               issue_tag, issue_op, op_rec[issue_tag], issue_bmask, cur_mask[issue_tag]);
        fail_count++;
    end

    sources_ready: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> s1ok[issue_tag] && s2ok[issue_tag])
    else begin
        $error("[ERROR] issue_tag %h src1 %h ready %h src2 %h ready %h", issue_tag,
               s1[issue_tag], s1ok[issue_tag], s2[issue_tag], s2ok[issue_tag]);
        fail_count++;
    end

    alu_completion: assert property (@(posedge clock) disable iff (reset)
        cdb_valid[0] == alu_exp && (!alu_exp || cdb_tag[0] == alu_t))
    else begin
        $error("[ERROR] cdb slot 0 valid %h tag %h expected valid %h tag %h",
               cdb_valid[0], cdb_tag[0], alu_exp, alu_t);
        fail_count++;
    end

    mul_completion: assert property (@(posedge clock) disable iff (reset)
        cdb_valid[1] == mul_exp && (!mul_exp || cdb_tag[1] == mul_t[`MUL_LAT-1]))
    else begin
        $error("[ERROR] cdb slot 1 valid %h tag %h expected valid %h tag %h",
               cdb_valid[1], cdb_tag[1], mul_exp, mul_t[`MUL_LAT-1]);
        fail_count++;
    end

    no_squashed_broadcast: assert property (@(posedge clock) disable iff (reset)
        !(cdb_valid[0] && squashed[cdb_tag[0]]) && !(cdb_valid[1] && squashed[cdb_tag[1]]))
    else begin
        $error("[ERROR] cdb_tag %h broadcast after squash", cdb_tag);
        fail_count++;
    end

endmodule

bind ooo_core ooo_checker checker_i (.*);

// File: logic/ooo_core.sv
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_core import ooo_pkg::*; (
    input  logic                                   clock,
    input  logic                                   reset,
    // dispatch
    input  logic [`CNT_W-1:0]                      dispatch_count,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_dest,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_src1,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   dispatch_src2,
    input  logic [`NUM_DISPATCH-1:0]               dispatch_src1_ready,
    input  logic [`NUM_DISPATCH-1:0]               dispatch_src2_ready,
    input  op_t  [`NUM_DISPATCH-1:0]               dispatch_op,
    input  logic [`NUM_DISPATCH-1:0][`BMASK_W-1:0] dispatch_bmask,
    output logic [`CNT_W-1:0]                      rs_spots,
    // branch
    input  logic [`BMASK_W-1:0]                    resolve_mask,
    input  logic                                   mispredict,
    // issue
    output logic                                   issue_valid,
    output logic [`TAG_W-1:0]                      issue_tag,
    output op_t                                    issue_op,
    output logic [`BMASK_W-1:0]                    issue_bmask,
    // common data bus
    output logic [`NUM_DISPATCH-1:0]               cdb_valid,
    output logic [`NUM_DISPATCH-1:0][`TAG_W-1:0]   cdb_tag
);

    // station view for the selector
    logic [`RS_SZ-1:0]               entry_valid;
    logic [`RS_SZ-1:0]               entry_ready;
    logic [`RS_SZ-1:0][`TAG_W-1:0]   entry_dest;
    op_t  [`RS_SZ-1:0]               entry_op;
    logic [`RS_SZ-1:0][`BMASK_W-1:0] entry_bmask;
    logic [`RS_SZ-1:0]               issue_clear;

    rs rs_i (
        .clock(clock),
        .reset(reset),
        .dispatch_count(dispatch_count),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src2_ready(dispatch_src2_ready),
        .dispatch_op(dispatch_op),
        .dispatch_bmask(dispatch_bmask),
        .rs_spots(rs_spots),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .resolve_mask(resolve_mask),
        .mispredict(mispredict),
        .issue_clear(issue_clear),
        .entry_valid(entry_valid),
        .entry_ready(entry_ready),
        .entry_dest(entry_dest),
        .entry_op(entry_op),
        .entry_bmask(entry_bmask)
    );

    issue_select issue_select_i (
        .clock(clock),
        .reset(reset),
        .entry_valid(entry_valid),
        .entry_ready(entry_ready),
        .entry_dest(entry_dest),
        .entry_op(entry_op),
        .entry_bmask(entry_bmask),
        .resolve_mask(resolve_mask),
        .mispredict(mispredict),
        .issue_clear(issue_clear),
        .issue_valid(issue_valid),
        .issue_tag(issue_tag),
        .issue_op(issue_op),
        .issue_bmask(issue_bmask)
    );

    // completions loop back to rs wakeup through cdb
    exec_unit exec_unit_i (
        .clock(clock),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_tag(issue_tag),
        .issue_op(issue_op),
        .issue_bmask(issue_bmask),
        .resolve_mask(resolve_mask),
        .mispredict(mispredict),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag)
    );

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ns
`include "ooo_defines.svh"

module exec_unit import ooo_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 issue_valid,
    input  logic [`TAG_W-1:0]                    issue_tag,
    input  op_t                                  issue_op,
    input  logic [`BMASK_W-1:0]                  issue_bmask,
    input  logic [`BMASK_W-1:0]                  resolve_mask,
    input  logic                                 mispredict,
    output logic [`NUM_DISPATCH-1:0]             cdb_valid,
    output logic [`NUM_DISPATCH-1:0][`TAG_W-1:0] cdb_tag
);

    // single ALU stage
    logic                alu_valid;
    logic [`TAG_W-1:0]   alu_tag;
    logic [`BMASK_W-1:0] alu_bmask;

    // multiplier shift pipeline, stage MUL_LAT-1 drives the bus
    logic [`MUL_LAT-1:0]               mul_valid;
    logic [`MUL_LAT-1:0][`TAG_W-1:0]   mul_tag;
    logic [`MUL_LAT-1:0][`BMASK_W-1:0] mul_bmask;

    logic                issue_kill;
    logic                is_mul;
    logic                alu_kill;
    logic [`MUL_LAT-1:0] mul_kill;

    assign is_mul     = (issue_op == OP_MUL);
    assign issue_kill = mispredict && |(issue_bmask & resolve_mask);
    assign alu_kill   = mispredict && |(alu_bmask & resolve_mask);

    always_comb begin
        for (int s = 0; s < `MUL_LAT; s++) begin
            mul_kill[s] = mispredict && |(mul_bmask[s] & resolve_mask);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            alu_valid    <= issue_valid && !is_mul && !issue_kill;
            mul_valid[0] <= issue_valid && is_mul && !issue_kill;
            for (int s = 1; s < `MUL_LAT; s++) begin
                mul_valid[s] <= mul_valid[s-1] && !mul_kill[s-1];
            end
        end
    end

    // masks lose resolved bits on every move
    always_ff @(posedge clock) begin
        alu_tag      <= issue_tag;
        alu_bmask    <= issue_bmask & ~resolve_mask;
        mul_tag[0]   <= issue_tag;
        mul_bmask[0] <= issue_bmask & ~resolve_mask;
        for (int s = 1; s < `MUL_LAT; s++) begin
            mul_tag[s]   <= mul_tag[s-1];
            mul_bmask[s] <= mul_bmask[s-1] & ~resolve_mask;
        end
    end

    // slot 0 for ALU, slot 1 for mul, an output stage under a mispredict is held off
    assign cdb_valid = {mul_valid[`MUL_LAT-1] && !mul_kill[`MUL_LAT-1],
                        alu_valid && !alu_kill};
    assign cdb_tag   = {mul_tag[`MUL_LAT-1], alu_tag};

endmodule

// File: logic/issue_select.sv
`timescale 1ns/1ns
`include "ooo_defines.svh"

module issue_select import ooo_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [`RS_SZ-1:0]               entry_valid,
    input  logic [`RS_SZ-1:0]               entry_ready,
    input  logic [`RS_SZ-1:0][`TAG_W-1:0]   entry_dest,
    input  op_t  [`RS_SZ-1:0]               entry_op,
    input  logic [`RS_SZ-1:0][`BMASK_W-1:0] entry_bmask,
    input  logic [`BMASK_W-1:0]             resolve_mask,
    input  logic                            mispredict,
    output logic [`RS_SZ-1:0]               issue_clear,
    output logic                            issue_valid,
    output logic [`TAG_W-1:0]               issue_tag,
    output op_t                             issue_op,
    output logic [`BMASK_W-1:0]             issue_bmask
);

    logic [`RS_SZ-1:0]      req;
    logic [0:0][`RS_SZ-1:0] gnt;
    logic [`TAG_W-1:0]      win_tag;
    op_t                    win_op;
    logic [`BMASK_W-1:0]    win_bmask;

    // candidates are valid, both sources ready, and not dying this cycle
    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            req[i] = entry_valid[i] && entry_ready[i]
                  && !(mispredict && |(entry_bmask[i] & resolve_mask));
        end
    end

    // lowest index wins
    psel_gen #(
        .WIDTH(`RS_SZ),
        .REQS(1)
    ) issue_psel (
        .req(req),
        .gnt_bus(gnt)
    );

    // one-hot, frees the entry at the next edge
    assign issue_clear = gnt[0];

    always_comb begin
        win_tag   = '0;
        win_op    = OP_ADD;
        win_bmask = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (gnt[0][i]) begin
                win_tag   = entry_dest[i];
                win_op    = entry_op[i];
                win_bmask = entry_bmask[i];
            end
        end
    end

    // reloaded every edge so a squashed op never lingers here
    // exec_unit drops it on capture when the mispredict hits this cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |gnt[0];
        end
    end

    always_ff @(posedge clock) begin
        issue_tag   <= win_tag;
        issue_op    <= win_op;
        issue_bmask <= win_bmask & ~resolve_mask;
    end

endmodule

// File: logic/rs.sv
`timescale 1ns/1ns
`include "ooo_defines.svh"

module rs import ooo_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,
    // dispatch side, valid for one cycle, no handshake
    input  logic [`CNT_W-1:0]                    dispatch_count,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0] dispatch_dest,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0] dispatch_src1,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0] dispatch_src2,
    input  logic [`NUM_DISPATCH-1:0]             dispatch_src1_ready,
    input  logic [`NUM_DISPATCH-1:0]             dispatch_src2_ready,
    input  op_t  [`NUM_DISPATCH-1:0]             dispatch_op,
    input  logic [`NUM_DISPATCH-1:0][`BMASK_W-1:0] dispatch_bmask,
    output logic [`CNT_W-1:0]                    rs_spots,
    // common data bus
    input  logic [`NUM_DISPATCH-1:0]             cdb_valid,
    input  logic [`NUM_DISPATCH-1:0][`TAG_W-1:0] cdb_tag,
    // branch resolution
    input  logic [`BMASK_W-1:0]                  resolve_mask,
    input  logic                                 mispredict,
    // issue side
    input  logic [`RS_SZ-1:0]                    issue_clear,
    output logic [`RS_SZ-1:0]                    entry_valid,
    output logic [`RS_SZ-1:0]                    entry_ready,
    output logic [`RS_SZ-1:0][`TAG_W-1:0]        entry_dest,
    output op_t  [`RS_SZ-1:0]                    entry_op,
    output logic [`RS_SZ-1:0][`BMASK_W-1:0]      entry_bmask
);

    localparam int FREE_W = $clog2(`RS_SZ + 1);

    // source tags and their ready bits are private to the station
    logic [`RS_SZ-1:0][`TAG_W-1:0]   src1_q;
    logic [`RS_SZ-1:0][`TAG_W-1:0]   src2_q;
    logic [`RS_SZ-1:0]               rdy1_q;
    logic [`RS_SZ-1:0]               rdy2_q;

    // next state of every entry
    logic [`RS_SZ-1:0]               valid_n;
    logic [`RS_SZ-1:0]               rdy1_n;
    logic [`RS_SZ-1:0]               rdy2_n;
    logic [`RS_SZ-1:0][`TAG_W-1:0]   dest_n;
    logic [`RS_SZ-1:0][`TAG_W-1:0]   src1_n;
    logic [`RS_SZ-1:0][`TAG_W-1:0]   src2_n;
    op_t  [`RS_SZ-1:0]               op_n;
    logic [`RS_SZ-1:0][`BMASK_W-1:0] bmask_n;

    logic [`NUM_DISPATCH-1:0][`RS_SZ-1:0] alloc_gnt;
    logic [FREE_W-1:0]                    free_cnt;

    // tag match against every valid bus slot
    function automatic logic cdb_hit(
        input logic [`TAG_W-1:0]                    tag,
        input logic [`NUM_DISPATCH-1:0]             bus_valid,
        input logic [`NUM_DISPATCH-1:0][`TAG_W-1:0] bus_tag
    );
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `NUM_DISPATCH; k++) begin
            if (bus_valid[k] && bus_tag[k] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // free slots for up to NUM_DISPATCH new instructions, lowest index first
    psel_gen #(
        .WIDTH(`RS_SZ),
        .REQS(`NUM_DISPATCH)
    ) alloc_psel (
        .req(~entry_valid),
        .gnt_bus(alloc_gnt)
    );

    // spots come from registered valid bits only
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (!entry_valid[i]) begin
                free_cnt = free_cnt + 1'b1;
            end
        end
        if (free_cnt > FREE_W'(`NUM_DISPATCH)) begin
            rs_spots = `CNT_W'(`NUM_DISPATCH);
        end else begin
            rs_spots = free_cnt[`CNT_W-1:0];
        end
    end

    always_comb begin
        valid_n = entry_valid;
        dest_n  = entry_dest;
        src1_n  = src1_q;
        src2_n  = src2_q;
        rdy1_n  = rdy1_q;
        rdy2_n  = rdy2_q;
        op_n    = entry_op;
        for (int i = 0; i < `RS_SZ; i++) begin
            // resolved branches drop out of the mask
            bmask_n[i] = entry_bmask[i] & ~resolve_mask;
            // squash anything under the mispredicted branch
            if (mispredict && |(entry_bmask[i] & resolve_mask)) begin
                valid_n[i] = 1'b0;
            end
            // wakeup
            if (cdb_hit(src1_q[i], cdb_valid, cdb_tag)) begin
                rdy1_n[i] = 1'b1;
            end
            if (cdb_hit(src2_q[i], cdb_valid, cdb_tag)) begin
                rdy2_n[i] = 1'b1;
            end
            if (issue_clear[i]) begin
                valid_n[i] = 1'b0;
            end
        end
        // new instructions land in granted free entries
        for (int k = 0; k < `NUM_DISPATCH; k++) begin
            for (int j = 0; j < `RS_SZ; j++) begin
                if (k < int'(dispatch_count) && alloc_gnt[k][j]) begin
                    // a dispatch under the branch being mispredicted dies on arrival
                    valid_n[j] = !(mispredict && |(dispatch_bmask[k] & resolve_mask));
                    dest_n[j]  = dispatch_dest[k];
                    src1_n[j]  = dispatch_src1[k];
                    src2_n[j]  = dispatch_src2[k];
                    // same-cycle broadcast counts as ready
                    rdy1_n[j]  = dispatch_src1_ready[k]
                               | cdb_hit(dispatch_src1[k], cdb_valid, cdb_tag);
                    rdy2_n[j]  = dispatch_src2_ready[k]
                               | cdb_hit(dispatch_src2[k], cdb_valid, cdb_tag);
                    op_n[j]    = dispatch_op[k];
                    bmask_n[j] = dispatch_bmask[k] & ~resolve_mask;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= valid_n;
        end
    end

    // entry payload, only meaningful where entry_valid is set
    always_ff @(posedge clock) begin
        entry_dest  <= dest_n;
        src1_q      <= src1_n;
        src2_q      <= src2_n;
        rdy1_q      <= rdy1_n;
        rdy2_q      <= rdy2_n;
        entry_op    <= op_n;
        entry_bmask <= bmask_n;
    end

    assign entry_ready = rdy1_q & rdy2_q;

endmodule

// File: logic/psel_gen.sv
`timescale 1ns/1ns

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    // grant k goes to the k-th lowest set request bit
    // grants beyond the number of set bits stay zero
    always_comb begin
        int found;
        found = 0;
        gnt_bus = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i]) begin
                for (int k = 0; k < REQS; k++) begin
                    // only the grant matching the running count takes this bit
                    if (found == k) begin
                        gnt_bus[k][i] = 1'b1;
                    end
                end
                found = found + 1;
            end
        end
    end

endmodule

// File: logic/ooo_pkg.sv
package ooo_pkg;

    // operation carried with each instruction
    // add, sub and and go to the ALU
    // mul goes to the pipelined multiplier
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_MUL = 2'd3
    } op_t;

endpackage

// File: logic/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// instructions accepted from dispatch per cycle
// also the number of common data bus slots
`define NUM_DISPATCH 2

// reservation station entries
`define RS_SZ 8

// physical tag width, 32 tags
`define TAG_W 5

// one bit per branch in flight
`define BMASK_W 4

// dispatch count and rs_spots width, holds 0 to NUM_DISPATCH
`define CNT_W 2

// multiplier pipeline depth
`define MUL_LAT 3

`endif
